/* dv/mem_stage_cases.txt */
// op addr store_data wdata_in mem_word wait, then expected sel mem_data wdata ce_we
// ce_we is 2 for a load, 3 for a store, 0 for no access; ffffffff ends the list
e0 00001000 00000000 5555aaaa 864df239 0 1 00000000 00000039 2
e0 00001001 00000000 5555aaaa 864df239 1 2 00000000 fffffff2 2
e0 00001002 00000000 5555aaaa 864df239 2 4 00000000 0000004d 2
e0 00001003 00000000 5555aaaa 864df239 3 8 00000000 ffffff86 2
e4 00001000 00000000 5555aaaa 864df239 4 1 00000000 00000039 2
e4 00001001 00000000 5555aaaa 864df239 5 2 00000000 000000f2 2
e4 00001002 00000000 5555aaaa 864df239 0 4 00000000 0000004d 2
e4 00001003 00000000 5555aaaa 864df239 1 8 00000000 00000086 2
e1 00002000 00000000 5555aaaa 864df239 2 3 00000000 fffff239 2
e1 00002002 00000000 5555aaaa 864df239 3 c 00000000 ffff864d 2
e5 00002000 00000000 5555aaaa 864df239 4 3 00000000 0000f239 2
e5 00002002 00000000 5555aaaa 864df239 5 c 00000000 0000864d 2
e3 00003000 00000000 5555aaaa 864df239 1 f 00000000 864df239 2
e0 00004004 00000000 5555aaaa 7be105c8 0 1 00000000 ffffffc8 2
e0 00004005 00000000 5555aaaa 7be105c8 2 2 00000000 00000005 2
e0 00004006 00000000 5555aaaa 7be105c8 3 4 00000000 ffffffe1 2
e0 00004007 00000000 5555aaaa 7be105c8 1 8 00000000 0000007b 2
e4 00004004 00000000 5555aaaa 7be105c8 4 1 00000000 000000c8 2
e1 00004008 00000000 5555aaaa 7be105c8 0 3 00000000 000005c8 2
e1 0000400a 00000000 5555aaaa 7be105c8 2 c 00000000 00007be1 2
e5 00004008 00000000 5555aaaa 7be105c8 5 3 00000000 000005c8 2
e3 0000400c 00000000 5555aaaa 7be105c8 3 f 00000000 7be105c8 2
e8 00005000 12345678 0badf00d 00000000 0 1 78787878 0badf00d 3
e8 00005001 12345678 0badf00d 00000000 1 2 78787878 0badf00d 3
e8 00005002 12345678 0badf00d 00000000 2 4 78787878 0badf00d 3
e8 00005003 12345678 0badf00d 00000000 3 8 78787878 0badf00d 3
e9 00005000 12345678 0badf00d 00000000 4 3 56785678 0badf00d 3
e9 00005002 12345678 0badf00d 00000000 5 c 56785678 0badf00d 3
eb 00005004 12345678 0badf00d 00000000 1 f 12345678 0badf00d 3
e8 00006002 a5c30fe1 13572468 00000000 2 4 e1e1e1e1 13572468 3
e9 00006006 a5c30fe1 13572468 00000000 0 c 0fe10fe1 13572468 3
eb 00006008 a5c30fe1 13572468 00000000 3 f a5c30fe1 13572468 3
e1 00007001 00000000 5555aaaa 864df239 2 0 00000000 00000000 0
e1 00007003 00000000 5555aaaa 864df239 2 0 00000000 00000000 0
e5 00007001 00000000 5555aaaa 864df239 2 0 00000000 00000000 0
e3 00007002 00000000 5555aaaa 864df239 2 0 00000000 00000000 0
e3 00007001 00000000 5555aaaa 864df239 2 0 00000000 00000000 0
e9 00007003 12345678 cafef00d 00000000 1 0 00000000 cafef00d 0
eb 00007002 12345678 cafef00d 00000000 1 0 00000000 cafef00d 0
eb 00007003 12345678 cafef00d 00000000 1 0 00000000 cafef00d 0
00 00000000 00000000 0badc0de 00000000 0 0 00000000 0badc0de 0
21 00008000 11223344 76543210 00000000 0 0 00000000 76543210 0
e2 00008002 11223344 89abcdef 00000000 0 0 00000000 89abcdef 0
ea 00008003 11223344 2468ace0 00000000 0 0 00000000 2468ace0 0
ff 00008004 11223344 fedcba98 00000000 0 0 00000000 fedcba98 0
ffffffff

/* list.f */
source/mem_access_pkg.sv
source/access_if.sv
source/access_decode.sv
source/lane_steer.sv
source/load_result.sv
source/mem_stage.sv
dv/mem_stage_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := mem_stage_tb
RTL_TOP   := mem_stage
FILE_LIST := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(RTL_TOP) -f $(FILE_LIST)
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/mem_stage_tb.sv */
// memory stage testbench

`timescale 1ns/1ps

module mem_stage_tb;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int cols         = 10;
    localparam int max_cases    = 64;
    localparam logic [1:0] kind_load  = 2'b10;
    localparam logic [1:0] kind_store = 2'b11;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic [7:0]  aluop_i;
    logic [31:0] mem_addr_i;
    logic [31:0] store_data_i;
    logic [4:0]  wd_i;
    logic        wreg_i;
    logic [31:0] wdata_i;
    logic [31:0] mem_data_i;
    logic        mem_data_valid_i;
    logic        mem_addr_ready_i;
    logic        mem_write_ready_i;
    logic [4:0]  wd_o;
    logic        wreg_o;
    logic [31:0] wdata_o;
    logic [31:0] mem_addr_o;
    logic [3:0]  mem_sel_o;
    logic [31:0] mem_data_o;
    logic        mem_ce_o;
    logic        mem_we_o;
    logic        mem_re_o;
    logic        stall_o;

    // ten words per case in case file column order
    logic [31:0] cases [0:max_cases*cols-1];
    integer      seed = 32'h2b4497b6;
    int          n_cases = 0;
    int          max_wait = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          errs = 0;
    int          failed = 0;

    mem_stage i_mem_stage (.*);

    always #(clk_period / 2) clk = ~clk;

    // watchdog
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout: memory handshake did not finish within %0d cycles", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errs++;
        end
    endtask

    task automatic verify_ctrl(input logic ce, input logic we, input logic re, input logic stall);
        check_val("mem_ce_o", 32'(mem_ce_o), 32'(ce));
        check_val("mem_we_o", 32'(mem_we_o), 32'(we));
        check_val("mem_re_o", 32'(mem_re_o), 32'(re));
        check_val("stall_o", 32'(stall_o), 32'(stall));
    endtask

    task automatic run_case(input int n);
        int         base;
        int         waits;
        int         lat;
        int         last;
        int         errs_before;
        logic [1:0] kind;
        base        = n * cols;
        kind        = cases[base + 9][1:0];
        waits       = cases[base + 5] + ($random(seed) & 3);
        lat         = $random(seed) & 1;
        errs_before = errs;
        if (kind == kind_load)
            last = waits + lat + 1;
        else if (kind == kind_store)
            last = waits;
        else
            last = 0;
        @(negedge clk);
        aluop_i      = cases[base][7:0];
        mem_addr_i   = cases[base + 1];
        store_data_i = cases[base + 2];
        wdata_i      = cases[base + 3];
        wd_i         = 5'($random(seed));
        wreg_i       = 1'($random(seed));
        // memory model takes the address after the wait and returns data later
        for (int c = 0; c <= last; c++)
        begin
            if (c > 0)
                @(negedge clk);
            mem_addr_ready_i  = (kind == kind_load) && (c == waits);
            mem_data_valid_i  = (kind == kind_load) && (c == last);
            mem_write_ready_i = (kind == kind_store) && (c == last);
            mem_data_i        = (c == last) ? cases[base + 4] : ~cases[base + 4];
            #(clk_period / 4);
            check_val("mem_sel_o", 32'(mem_sel_o), cases[base + 6]);
            check_val("mem_data_o", mem_data_o, cases[base + 7]);
            check_val("wd_o", 32'(wd_o), 32'(wd_i));
            check_val("wreg_o", 32'(wreg_o), 32'(wreg_i));
            if (kind == kind_load)
                verify_ctrl(1'b1, 1'b0, c <= waits, c != last);
            else if (kind == kind_store)
                verify_ctrl(1'b1, 1'b1, 1'b0, c != last);
            else
                verify_ctrl(1'b0, 1'b0, 1'b0, 1'b0);
            if (kind == kind_load || kind == kind_store)
                check_val("mem_addr_o", mem_addr_o, mem_addr_i);
        end
        // write-back word is final once the stall drops
        check_val("wdata_o", wdata_o, cases[base + 8]);
        if (errs != errs_before)
            failed++;
        $display("case %0d op %h: %s", n, aluop_i, (errs == errs_before) ? "ok" : "error");
    endtask

    initial
    begin
        rst_n_i           = 1'b0;
        aluop_i           = 8'h00;
        mem_addr_i        = 32'h0;
        store_data_i      = 32'h0;
        wd_i              = 5'h0;
        wreg_i            = 1'b0;
        wdata_i           = 32'h0;
        mem_data_i        = 32'h0;
        mem_data_valid_i  = 1'b0;
        mem_addr_ready_i  = 1'b0;
        mem_write_ready_i = 1'b0;
        $readmemh("dv/mem_stage_cases.txt", cases);
        while (n_cases < max_cases && cases[n_cases * cols] != 32'hffff_ffff)
        begin
            if (int'(cases[n_cases * cols + 5]) > max_wait)
                max_wait = int'(cases[n_cases * cols + 5]);
            n_cases++;
        end
        cycle_limit = n_cases * (max_wait + 8) + reset_cycles + 2;
        repeat (reset_cycles) @(negedge clk);
        rst_n_i = 1'b1;
        #(clk_period / 4);
        // idle stage out of reset
        verify_ctrl(1'b0, 1'b0, 1'b0, 1'b0);
        $display("reset check: %s", (errs == 0) ? "ok" : "error");
        if (n_cases == 0)
        begin
            $display("no test cases were read from the case file");
            errs++;
        end
        for (int n = 0; n < n_cases; n++)
            run_case(n);
        $display("cases %0d, failed %0d, errors %0d", n_cases, failed, errs);
        if (errs == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* source/mem_stage.sv */
// mips memory access stage

`timescale 1ns/1ps

module mem_stage (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic [mem_access_pkg::aluop_w-1:0]    aluop_i,
    input  logic [mem_access_pkg::word_w-1:0]     mem_addr_i,
    input  logic [mem_access_pkg::word_w-1:0]     store_data_i,
    input  logic [mem_access_pkg::reg_addr_w-1:0] wd_i,
    input  logic                                  wreg_i,
    input  logic [mem_access_pkg::word_w-1:0]     wdata_i,
    input  logic [mem_access_pkg::word_w-1:0]     mem_data_i,
    input  logic                                  mem_data_valid_i,
    input  logic                                  mem_addr_ready_i,
    input  logic                                  mem_write_ready_i,
    output logic [mem_access_pkg::reg_addr_w-1:0] wd_o,
    output logic                                  wreg_o,
    output logic [mem_access_pkg::word_w-1:0]     wdata_o,
    output logic [mem_access_pkg::word_w-1:0]     mem_addr_o,
    output logic [mem_access_pkg::lanes-1:0]      mem_sel_o,
    output logic [mem_access_pkg::word_w-1:0]     mem_data_o,
    output logic                                  mem_ce_o,
    output logic                                  mem_we_o,
    output logic                                  mem_re_o,
    output logic                                  stall_o
);

    access_if acc ();

    // register write target is not touched by this stage
    assign wd_o   = wd_i;
    assign wreg_o = wreg_i;

    access_decode i_access_decode (
        .aluop_i   (aluop_i),
        .addr_lo_i (mem_addr_i[1:0]),
        .acc       (acc.decoder)
    );

    lane_steer i_lane_steer (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .acc               (acc.steer),
        .addr_i            (mem_addr_i),
        .store_data_i      (store_data_i),
        .mem_addr_ready_i  (mem_addr_ready_i),
        .mem_data_valid_i  (mem_data_valid_i),
        .mem_write_ready_i (mem_write_ready_i),
        .mem_addr_o        (mem_addr_o),
        .mem_sel_o         (mem_sel_o),
        .mem_data_o        (mem_data_o),
        .mem_ce_o          (mem_ce_o),
        .mem_we_o          (mem_we_o),
        .mem_re_o          (mem_re_o),
        .stall_o           (stall_o)
    );

    load_result i_load_result (
        .acc        (acc.result),
        .mem_data_i (mem_data_i),
        .wdata_i    (wdata_i),
        .wdata_o    (wdata_o)
    );

endmodule

/* source/load_result.sv */
// load data extraction and extension

`timescale 1ns/1ps

module load_result (
    access_if.result                          acc,
    input  logic [mem_access_pkg::word_w-1:0] mem_data_i,
    input  logic [mem_access_pkg::word_w-1:0] wdata_i,
    output logic [mem_access_pkg::word_w-1:0] wdata_o
);

    mem_access_pkg::lane_word_u rd_word;
    logic [7:0]                 ld_byte;
    logic [15:0]                ld_half;
    logic                       is_load;
    logic                       byte_fill;
    logic                       half_fill;

    assign rd_word = mem_data_i;

    // lane picked by the low address bits
    assign ld_byte = rd_word.lane_b[acc.offset];
    assign ld_half = rd_word.lane_h[acc.offset[1]];

    assign is_load = acc.valid & ~acc.is_store;

    // sign bit or zero for the upper part
    assign byte_fill = acc.sign_ext & ld_byte[7];
    assign half_fill = acc.sign_ext & ld_half[15];

    always_comb
    begin
        if (is_load)
        begin
            case (acc.size)
                mem_access_pkg::size_byte:
                begin
                    wdata_o = {{(mem_access_pkg::word_w-8){byte_fill}}, ld_byte};
                end
                mem_access_pkg::size_half:
                begin
                    wdata_o = {{(mem_access_pkg::word_w-16){half_fill}}, ld_half};
                end
                default:
                begin
                    wdata_o = mem_data_i;
                end
            endcase
        end
        else if (acc.is_load_op)
        begin
            // load rejected by decode as misaligned
            wdata_o = mem_access_pkg::zero_word;
        end
        else
        begin
            // stores and non memory instructions
            wdata_o = wdata_i;
        end
    end

endmodule

/* source/lane_steer.sv */
// memory request and stall control

`timescale 1ns/1ps

module lane_steer (
    input  logic                              clk,
    input  logic                              rst_n_i,
    access_if.steer                           acc,
    input  logic [mem_access_pkg::word_w-1:0] addr_i,
    input  logic [mem_access_pkg::word_w-1:0] store_data_i,
    input  logic                              mem_addr_ready_i,
    input  logic                              mem_data_valid_i,
    input  logic                              mem_write_ready_i,
    output logic [mem_access_pkg::word_w-1:0] mem_addr_o,
    output logic [mem_access_pkg::lanes-1:0]  mem_sel_o,
    output logic [mem_access_pkg::word_w-1:0] mem_data_o,
    output logic                              mem_ce_o,
    output logic                              mem_we_o,
    output logic                              mem_re_o,
    output logic                              stall_o
);

    mem_access_pkg::lane_word_u st_word;
    logic                       rd_req;
    logic                       wr_req;
    logic                       rd_accepted;

    assign st_word = store_data_i;
    assign rd_req  = acc.valid & ~acc.is_store;
    assign wr_req  = acc.valid & acc.is_store;

    assign mem_ce_o   = acc.valid;
    assign mem_we_o   = wr_req;
    assign mem_addr_o = acc.valid ? addr_i : mem_access_pkg::zero_word;

    // byte selects follow size and offset
    always_comb
    begin
        mem_sel_o = mem_access_pkg::sel_none;
        if (acc.valid)
        begin
            case (acc.size)
                mem_access_pkg::size_byte: mem_sel_o = 4'b0001 << acc.offset;
                mem_access_pkg::size_half: mem_sel_o = acc.offset[1] ? 4'b1100 : 4'b0011;
                default:                   mem_sel_o = mem_access_pkg::sel_all;
            endcase
        end
    end

    // store data replicated over every lane the select may pick
    always_comb
    begin
        mem_data_o = mem_access_pkg::zero_word;
        if (wr_req)
        begin
            case (acc.size)
                mem_access_pkg::size_byte:
                begin
                    mem_data_o = {4{st_word.lane_b[0]}};
                end
                mem_access_pkg::size_half:
                begin
                    mem_data_o = {2{st_word.lane_b[1], st_word.lane_b[0]}};
                end
                default:
                begin
                    mem_data_o = store_data_i;
                end
            endcase
        end
    end

    // set once the memory takes the read address, cleared by returned data
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rd_accepted <= 1'b0;
        end
        else if (mem_re_o && mem_addr_ready_i)
        begin
            rd_accepted <= 1'b1;
        end
        else if (mem_data_valid_i)
        begin
            rd_accepted <= 1'b0;
        end
    end

    assign mem_re_o = rd_req & ~rd_accepted;

    // hold the pipeline until data returns or the write is taken
    assign stall_o = (rd_req & ~mem_data_valid_i) | (wr_req & ~mem_write_ready_i);

endmodule

/* source/access_decode.sv */
// load and store opcode decode

`timescale 1ns/1ps

module access_decode (
    input  logic [mem_access_pkg::aluop_w-1:0] aluop_i,
    input  logic [1:0]                         addr_lo_i,
    access_if.decoder                          acc
);

    logic                       known;
    logic                       aligned;
    logic                       is_store;
    logic                       sign_ext;
    mem_access_pkg::access_size size;

    always_comb
    begin
        known    = 1'b1;
        is_store = 1'b0;
        sign_ext = 1'b0;
        size     = mem_access_pkg::size_byte;
        case (aluop_i)
            mem_access_pkg::op_lb:
            begin
                sign_ext = 1'b1;
            end
            mem_access_pkg::op_lbu:
            begin
                size = mem_access_pkg::size_byte;
            end
            mem_access_pkg::op_lh:
            begin
                size     = mem_access_pkg::size_half;
                sign_ext = 1'b1;
            end
            mem_access_pkg::op_lhu:
            begin
                size = mem_access_pkg::size_half;
            end
            mem_access_pkg::op_lw:
            begin
                size = mem_access_pkg::size_word;
            end
            mem_access_pkg::op_sb:
            begin
                is_store = 1'b1;
            end
            mem_access_pkg::op_sh:
            begin
                size     = mem_access_pkg::size_half;
                is_store = 1'b1;
            end
            mem_access_pkg::op_sw:
            begin
                size     = mem_access_pkg::size_word;
                is_store = 1'b1;
            end
            default:
            begin
                // not a memory instruction
                known = 1'b0;
            end
        endcase
    end

    // halves on even offsets, words on offset 0 only
    always_comb
    begin
        case (size)
            mem_access_pkg::size_half: aligned = ~addr_lo_i[0];
            mem_access_pkg::size_word: aligned = (addr_lo_i == 2'b00);
            default:                   aligned = 1'b1;
        endcase
    end

    assign acc.valid      = known & aligned;
    assign acc.is_store   = is_store;
    assign acc.is_load_op = known & ~is_store;
    assign acc.size       = size;
    assign acc.sign_ext   = sign_ext;
    assign acc.offset     = addr_lo_i;

endmodule

/* source/access_if.sv */
// decoded memory access

`timescale 1ns/1ps

interface access_if;

    logic                       valid;
    logic                       is_store;
    // opcode names a load, even when the access itself was rejected
    logic                       is_load_op;
    mem_access_pkg::access_size size;
    logic                       sign_ext;
    // low two address bits
    logic [1:0]                 offset;

    modport decoder (
        output valid, is_store, is_load_op, size, sign_ext, offset
    );

    modport steer (
        input valid, is_store, size, offset
    );

    modport result (
        input valid, is_store, is_load_op, size, sign_ext, offset
    );

endinterface

/* source/mem_access_pkg.sv */
// memory access stage definitions

package mem_access_pkg;

    // data path widths
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int aluop_w    = 8;
    localparam int lanes      = 4;

    // load opcodes in the execute stage alu op encoding
    localparam logic [aluop_w-1:0] op_lb  = 8'b1110_0000;
    localparam logic [aluop_w-1:0] op_lbu = 8'b1110_0100;
    localparam logic [aluop_w-1:0] op_lh  = 8'b1110_0001;
    localparam logic [aluop_w-1:0] op_lhu = 8'b1110_0101;
    localparam logic [aluop_w-1:0] op_lw  = 8'b1110_0011;

    // store opcodes
    localparam logic [aluop_w-1:0] op_sb  = 8'b1110_1000;
    localparam logic [aluop_w-1:0] op_sh  = 8'b1110_1001;
    localparam logic [aluop_w-1:0] op_sw  = 8'b1110_1011;

    // access size of a decoded load or store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size;

    // byte lane selects
    localparam logic [lanes-1:0] sel_none = 4'b0000;
    localparam logic [lanes-1:0] sel_all  = 4'b1111;

    localparam logic [word_w-1:0] zero_word = '0;

    // one memory word as byte lanes or as halfword lanes
    // lane 0 is the least significant byte
    typedef union packed {
        logic [lanes-1:0][7:0]     lane_b;
        logic [lanes/2-1:0][15:0]  lane_h;
    } lane_word_u;

endpackage
